//--- flist.f
common/rv32i_pkg.sv
hdl/ctrl_pipe.sv
hdl/stall_control_unit.sv
predictor/branch_target_buffer.sv
predictor/gshare_predictor.sv
hdl/pipeline_control_top.sv
verification/tb_pipeline_control.sv

//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert
TOP     = tb_pipeline_control
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_pipeline_control.sv
`timescale 1ns/1ns

module tb_pipeline_control
    import rv32i_pkg::*;
();

    localparam int TEST_CYCLES = 600;

    logic clk = 1'b0, rst_n, instr_mem_resp, data_mem_resp, id_br_en, jalr_wrong_target;
    word_t id_instr, if_pc, id_pc, id_target, if_pred_target;
    logic load_pc, if_id_reg_load, id_ex_reg_load, ex_mem_reg_load, mem_wb_reg_load;
    logic if_id_reg_flush, id_ex_reg_flush, ex_mem_reg_flush, mem_wb_reg_flush, global_stall;
    pcmux_sel_t pc_mux_sel;
    opcode_t wb_opcode;
    reg_id_t wb_rd;

    int errors = 0;
    int cycles = 0;
    int unsigned rng_state = 63760;

    // reference model state
    logic m_id_valid;
    opcode_t m_ex_op, m_mem_op, m_wb_op;
    funct3_t m_ex_f3;
    reg_id_t m_ex_rd, m_ex_rs1, m_ex_rs2, m_mem_rd, m_wb_rd;
    logic [15:0] m_bv;
    logic [25:0] m_btag [16];
    word_t m_btgt [16];
    br_kind_t m_bkind [16];
    ghr_t m_ghr, m_id_pcb, m_id_ghr;
    ctr_t m_pht [16];
    logic m_id_pr;

    // expected responses
    opcode_t e_op;
    funct3_t e_f3;
    reg_id_t e_rs1, e_rs2, e_rd;
    logic e_cmp, ex_arith, ex_alu, dep_ex, dep_mem, e_raw, e_alu_st, e_cache;
    logic if_hit, id_hit, if_pr;
    logic [4:0] exp_loads;
    logic [3:0] exp_flush;
    pcmux_sel_t exp_sel;
    logic exp_btb_load, exp_ghr, exp_inc, exp_dec;
    word_t exp_if_tgt;
    ghr_t id_pht_idx;

    pipeline_control_top UUT (.*);

    always #10 clk = ~clk;

    always_comb
    begin
        e_op  = m_id_valid ? id_instr[6:0] : op_bubble;
        e_f3  = m_id_valid ? id_instr[14:12] : '0;
        e_rs1 = m_id_valid ? id_instr[19:15] : '0;
        e_rs2 = m_id_valid ? id_instr[24:20] : '0;
        e_rd  = (e_op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_imm, op_reg}) ?
                id_instr[11:7] : '0;
        e_cmp = (e_op == op_br) ||
                ((e_op == op_reg || e_op == op_imm) && (e_f3 == f3_slt || e_f3 == f3_sltu));
        ex_arith = (m_ex_op == op_reg || m_ex_op == op_imm) &&
                   m_ex_f3 != f3_slt && m_ex_f3 != f3_sltu;
        ex_alu  = ex_arith || m_ex_op == op_auipc;
        dep_ex  = m_ex_rd != 0 && (m_ex_rd == e_rs1 || (e_cmp && m_ex_rd == e_rs2));
        dep_mem = m_mem_rd != 0 && (m_mem_rd == e_rs1 || (e_cmp && m_mem_rd == e_rs2));
        e_raw = (e_cmp || e_op == op_jalr) &&
                (((ex_alu || m_ex_op == op_load) && dep_ex) || (m_mem_op == op_load && dep_mem));
        e_alu_st = (ex_arith || m_ex_op == op_store) && m_mem_op == op_load && m_mem_rd != 0 &&
                   (m_mem_rd == m_ex_rs1 || (ex_arith && m_mem_rd == m_ex_rs2));
        e_cache = !instr_mem_resp ||
                  (!data_mem_resp && (m_mem_op == op_load || m_mem_op == op_store));
        if_hit = m_bv[if_pc[5:2]] && m_btag[if_pc[5:2]] == if_pc[31:6];
        id_hit = m_bv[id_pc[5:2]] && m_btag[id_pc[5:2]] == id_pc[31:6];
        if_pr  = m_pht[if_pc[5:2] ^ m_ghr][1];
        exp_if_tgt = m_btgt[if_pc[5:2]];
        id_pht_idx = m_id_pcb ^ m_id_ghr;
        exp_loads = 5'b11111;
        exp_flush = 4'b0000;
        exp_sel = PC_PLUS4;
        exp_btb_load = 1'b0;
        exp_ghr = 1'b0;
        exp_inc = 1'b0;
        exp_dec = 1'b0;
        if (e_raw)
        begin
            exp_loads = 5'b00111;
            exp_flush = 4'b0100;
        end
        if (e_alu_st)
        begin
            exp_loads = 5'b00011;
            exp_flush = 4'b0010;
        end
        if (if_hit && (m_bkind[if_pc[5:2]] != KIND_BR || if_pr))
            exp_sel = BTB_OUT;
        if (!e_raw && !e_alu_st)
        begin
            if (e_op == op_br && id_hit && m_id_pr != id_br_en)
            begin
                exp_flush[3] = 1'b1;
                exp_sel = id_br_en ? ADDER_OUT : IF_ID_PC_PLUS4;
            end
            else if ((e_op == op_br && !id_hit && id_br_en) || (e_op == op_jal && !id_hit))
            begin
                exp_flush[3] = 1'b1;
                exp_btb_load = 1'b1;
                exp_sel = ADDER_OUT;
            end
            else if (e_op == op_jalr && (!id_hit || jalr_wrong_target))
            begin
                exp_flush[3] = 1'b1;
                exp_btb_load = 1'b1;
                exp_sel = ADDER_MOD2;
            end
            if (e_op == op_br)
            begin
                exp_ghr = 1'b1;
                exp_inc = id_br_en;
                exp_dec = !id_br_en;
            end
        end
        if (e_cache)
        begin
            exp_loads = 5'b00000;
            exp_flush = 4'b0000;
            exp_btb_load = 1'b0;
            exp_ghr = 1'b0;
            exp_inc = 1'b0;
            exp_dec = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_id_valid <= 1'b0;
            {m_ex_op, m_ex_f3, m_ex_rd, m_ex_rs1, m_ex_rs2} <= '0;
            {m_mem_op, m_mem_rd} <= '0;
            {m_wb_op, m_wb_rd} <= '0;
            m_bv <= '0;
            {m_ghr, m_id_pcb, m_id_ghr, m_id_pr} <= '0;
            for (int i = 0; i < 16; i++)
                m_pht[i] <= PHT_INIT;
        end
        else
        begin
            cycles <= cycles + 1;
            if (exp_flush[3])
                {m_id_valid, m_id_pr, m_id_pcb, m_id_ghr} <= '0;
            else if (exp_loads[3])
                {m_id_valid, m_id_pr, m_id_pcb, m_id_ghr} <= {1'b1, if_pr, if_pc[5:2], m_ghr};
            if (exp_flush[2])
                {m_ex_op, m_ex_f3, m_ex_rd, m_ex_rs1, m_ex_rs2} <= '0;
            else if (exp_loads[2])
                {m_ex_op, m_ex_f3, m_ex_rd, m_ex_rs1, m_ex_rs2} <=
                    {e_op, e_f3, e_rd, e_rs1, e_rs2};
            if (exp_flush[1])
                {m_mem_op, m_mem_rd} <= '0;
            else if (exp_loads[1])
                {m_mem_op, m_mem_rd} <= {m_ex_op, m_ex_rd};
            if (exp_flush[0])
                {m_wb_op, m_wb_rd} <= '0;
            else if (exp_loads[0])
                {m_wb_op, m_wb_rd} <= {m_mem_op, m_mem_rd};
            if (exp_btb_load)
            begin
                m_bv[id_pc[5:2]] <= 1'b1;
                m_btag[id_pc[5:2]] <= id_pc[31:6];
                m_btgt[id_pc[5:2]] <= id_target;
                m_bkind[id_pc[5:2]] <= (e_op == op_jal) ? KIND_JAL :
                                       (e_op == op_jalr) ? KIND_JALR : KIND_BR;
            end
            if (exp_ghr)
                m_ghr <= {m_ghr[2:0], id_br_en};
            if (exp_inc && m_pht[id_pht_idx] != 2'd3)
                m_pht[id_pht_idx] <= m_pht[id_pht_idx] + 2'd1;
            else if (exp_dec && m_pht[id_pht_idx] != 2'd0)
                m_pht[id_pht_idx] <= m_pht[id_pht_idx] - 2'd1;
        end
    end

    task automatic report_mismatch(input string what);
        errors++;
        $display("Mismatch at %0t ns: %s", $time, what);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n)
        {load_pc, if_id_reg_load, id_ex_reg_load, ex_mem_reg_load, mem_wb_reg_load} == exp_loads)
        else report_mismatch("register loads");
    assert property (@(posedge clk) disable iff (!rst_n)
        {if_id_reg_flush, id_ex_reg_flush, ex_mem_reg_flush, mem_wb_reg_flush} == exp_flush)
        else report_mismatch("register flushes");
    assert property (@(posedge clk) disable iff (!rst_n) pc_mux_sel == exp_sel)
        else report_mismatch("pc mux select");
    assert property (@(posedge clk) disable iff (!rst_n) global_stall == e_cache)
        else report_mismatch("global stall");
    assert property (@(posedge clk) disable iff (!rst_n)
        {UUT.btb_load, UUT.ghr_load, UUT.increment_pht, UUT.decrement_pht} ==
        {exp_btb_load, exp_ghr, exp_inc, exp_dec})
        else report_mismatch("predictor update strobes");
    assert property (@(posedge clk) disable iff (!rst_n) if_hit |-> if_pred_target == exp_if_tgt)
        else report_mismatch("btb target for if_pc");
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_opcode == m_wb_op && wb_rd == m_wb_rd)
        else report_mismatch("mem/wb control fields");

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    function automatic reg_id_t rand_reg();
        return reg_id_t'(1 + next_rand() % 31);
    endfunction

    function automatic word_t enc_load(reg_id_t rd, reg_id_t rs1);
        return {12'd0, rs1, 3'b010, rd, op_load};
    endfunction

    function automatic word_t enc_br(reg_id_t rs1, reg_id_t rs2);
        return {7'd0, rs2, rs1, 3'b000, 5'd0, op_br};
    endfunction

    function automatic word_t enc_add(reg_id_t rd, reg_id_t rs1, reg_id_t rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, op_reg};
    endfunction

    task automatic drive(input word_t instr, input word_t ipc, input word_t dpc, input logic br_en,
                         input word_t tgt, input logic jwrong, input logic imem, input logic dmem);
        @(negedge clk);
        id_instr = instr;
        if_pc = ipc;
        id_pc = dpc;
        id_br_en = br_en;
        id_target = tgt;
        jalr_wrong_target = jwrong;
        instr_mem_resp = imem;
        data_mem_resp = dmem;
    endtask

    // repeats the ID instruction until the model lets it leave ID
    task automatic issue(input word_t instr, input word_t ipc, input word_t dpc, input logic br_en,
                         input word_t tgt, input logic jwrong);
        int tries;
        tries = 0;
        drive(instr, ipc, dpc, br_en, tgt, jwrong, 1'b1, 1'b1);
        #1;
        while (!exp_loads[3] && tries < 8)
        begin
            drive(instr, ipc, dpc, br_en, tgt, jwrong, 1'b1, 1'b1);
            #1;
            tries++;
        end
    endtask

    task automatic step(input word_t instr);
        issue(instr, 32'h100, 32'h0fc, 1'b0, 32'h0, 1'b0);
    endtask

    initial
    begin
        #(TEST_CYCLES * 20 + 1000);
        $display("watchdog expired before the test sequence finished");
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        reg_id_t r;
        word_t nop;
        int gap;
        nop = 32'h0000_0013;
        rst_n = 1'b0;
        {id_instr, if_pc, id_pc, id_target} = '0;
        {id_br_en, jalr_wrong_target} = '0;
        instr_mem_resp = 1'b1;
        data_mem_resp = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        repeat (3) step(nop);

        // load-use on branch, jalr and alu, plus non-matching and x0 pairs
        for (int n = 0; n < 6; n++)
        begin
            r = rand_reg();
            step(enc_load(r, 5'd1));
            step(enc_br(r, 5'd2));
            step(enc_load(r, 5'd1));
            step(enc_br((r == 5'd31) ? 5'd1 : r + 5'd1, 5'd0));
            step(enc_load(5'd0, 5'd1));
            step(enc_br(5'd0, 5'd0));
            step(enc_load(r, 5'd1));
            step(nop);
            step({12'd0, r, 3'b000, 5'd1, op_jalr});
            step(nop);
            step(enc_load(r, 5'd1));
            step(enc_add(5'd7, r, 5'd3));
            repeat (3) step(nop);
        end

        // instruction misses, then data misses with and without a mem-stage access
        gap = 1 + next_rand() % 4;
        repeat (gap) drive(nop, 32'h100, 32'h0fc, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1);
        step(enc_load(5'd4, 5'd1));
        step(nop);
        gap = 1 + next_rand() % 4;
        repeat (gap) drive(nop, 32'h100, 32'h0fc, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        repeat (3) step(nop);
        repeat (2) drive(nop, 32'h100, 32'h0fc, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        step(nop);

        // miss on a hazard cycle
        r = rand_reg();
        step(enc_load(r, 5'd1));
        drive(enc_br(r, 5'd2), 32'h100, 32'h0fc, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1);
        step(enc_br(r, 5'd2));
        repeat (3) step(nop);

        // btb fill for branch, jal and jalr
        issue(enc_br(5'd1, 5'd2), 32'h1044, 32'h1040, 1'b1, 32'h2000, 1'b0);
        step(nop);
        issue(nop, 32'h1040, 32'h0fc, 1'b0, 32'h0, 1'b0);
        issue({20'd0, 5'd1, op_jal}, 32'h300c, 32'h3008, 1'b0, 32'h4000, 1'b0);
        step(nop);
        issue(nop, 32'h3008, 32'h0fc, 1'b0, 32'h0, 1'b0);
        issue({12'd0, 5'd2, 3'b000, 5'd1, op_jalr}, 32'h5014, 32'h5010, 1'b0, 32'h6000, 1'b0);
        step(nop);
        issue({12'd0, 5'd2, 3'b000, 5'd1, op_jalr}, 32'h5014, 32'h5010, 1'b0, 32'h6100, 1'b1);
        step(nop);
        issue({12'd0, 5'd2, 3'b000, 5'd1, op_jalr}, 32'h5014, 32'h5010, 1'b0, 32'h6100, 1'b0);
        repeat (2) step(nop);

        // gshare training on one branch and a final not-taken surprise
        for (int n = 0; n < 10; n++)
        begin
            issue(nop, 32'h7020, 32'h0fc, 1'b0, 32'h0, 1'b0);
            issue(enc_br(5'd3, 5'd4), 32'h7024, 32'h7020, 1'b1, 32'h8000, 1'b0);
            step(nop);
        end
        issue(nop, 32'h7020, 32'h0fc, 1'b0, 32'h0, 1'b0);
        issue(enc_br(5'd3, 5'd4), 32'h7024, 32'h7020, 1'b0, 32'h8000, 1'b0);
        repeat (3) step(nop);

        $display("checked %0d cycles, %0d errors", cycles, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- hdl/pipeline_control_top.sv
`timescale 1ns/1ns

module pipeline_control_top
    import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_mem_resp,
    input  logic       data_mem_resp,
    input  word_t      id_instr,
    input  word_t      if_pc,
    input  word_t      id_pc,
    input  logic       id_br_en,
    input  word_t      id_target,
    input  logic       jalr_wrong_target,
    output logic       load_pc,
    output logic       if_id_reg_load,
    output logic       id_ex_reg_load,
    output logic       ex_mem_reg_load,
    output logic       mem_wb_reg_load,
    output logic       if_id_reg_flush,
    output logic       id_ex_reg_flush,
    output logic       ex_mem_reg_flush,
    output logic       mem_wb_reg_flush,
    output pcmux_sel_t pc_mux_sel,
    output logic       global_stall,
    output word_t      if_pred_target,
    output opcode_t    wb_opcode,
    output reg_id_t    wb_rd
);

    // decoded ID fields
    opcode_t  id_opcode;
    funct3_t  id_funct3;
    reg_id_t  id_rs1;
    reg_id_t  id_rs2;

    // EX and MEM control fields
    opcode_t  ex_opcode;
    funct3_t  ex_funct3;
    reg_id_t  ex_rd;
    reg_id_t  ex_rs1;
    reg_id_t  ex_rs2;
    opcode_t  mem_opcode;
    reg_id_t  mem_rd;
    logic     mem_read;
    logic     mem_write;

    // predictor lookups and update strobes
    logic     if_btb_hit;
    br_kind_t if_btb_kind;
    logic     id_btb_hit;
    logic     if_br_pr;
    logic     id_br_pr;
    logic     btb_load;
    logic     ghr_load;
    logic     increment_pht;
    logic     decrement_pht;

    ctrl_pipe u_ctrl_pipe (.*);

    stall_control_unit u_stall_control_unit (.*);

    branch_target_buffer u_branch_target_buffer (.*);

    gshare_predictor u_gshare_predictor (.*);

endmodule

//--- predictor/gshare_predictor.sv
`timescale 1ns/1ns

module gshare_predictor
    import rv32i_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t if_pc,
    input  logic  id_br_en,
    input  logic  if_id_reg_load,
    input  logic  if_id_reg_flush,
    input  logic  ghr_load,
    input  logic  increment_pht,
    input  logic  decrement_pht,
    output logic  if_br_pr,
    output logic  id_br_pr
);

    ghr_t ghr;
    ctr_t pht [PHT_ENTRIES];

    ghr_t if_index;
    ghr_t id_pc_bits;
    ghr_t id_ghr;
    ghr_t id_index;

    assign if_index = if_pc[GHR_BITS+1:2] ^ ghr;
    assign if_br_pr = pht[if_index][1];

    // rebuilt from the pc bits and history seen at fetch
    assign id_index = id_pc_bits ^ id_ghr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ghr <= '0;
        else if (ghr_load)
            ghr <= {ghr[GHR_BITS-2:0], id_br_en};
    end

    // fetch-time state that follows the instruction into ID
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            id_br_pr   <= 1'b0;
            id_pc_bits <= '0;
            id_ghr     <= '0;
        end
        else if (if_id_reg_flush)
        begin
            id_br_pr   <= 1'b0;
            id_pc_bits <= '0;
            id_ghr     <= '0;
        end
        else if (if_id_reg_load)
        begin
            id_br_pr   <= if_br_pr;
            id_pc_bits <= if_pc[GHR_BITS+1:2];
            id_ghr     <= ghr;
        end
    end

    // saturating 2-bit counters
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < PHT_ENTRIES; i++)
                pht[i] <= PHT_INIT;
        end
        else if (increment_pht && (pht[id_index] != CTR_MAX))
            pht[id_index] <= pht[id_index] + 2'd1;
        else if (decrement_pht && (pht[id_index] != 2'd0))
            pht[id_index] <= pht[id_index] - 2'd1;
    end

endmodule

//--- predictor/branch_target_buffer.sv
`timescale 1ns/1ns

module branch_target_buffer
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    if_pc,
    input  word_t    id_pc,
    input  word_t    id_target,
    input  opcode_t  id_opcode,
    input  logic     btb_load,
    output logic     if_btb_hit,
    output br_kind_t if_btb_kind,
    output word_t    if_pred_target,
    output logic     id_btb_hit
);

    logic [BTB_ENTRIES-1:0] valid;
    btb_tag_t               tags    [BTB_ENTRIES];
    word_t                  targets [BTB_ENTRIES];
    br_kind_t               kinds   [BTB_ENTRIES];

    btb_index_t if_index;
    btb_index_t id_index;
    btb_tag_t   if_tag;
    btb_tag_t   id_tag;
    br_kind_t   id_kind;

    assign if_index = if_pc[BTB_INDEX_BITS+1:2];
    assign id_index = id_pc[BTB_INDEX_BITS+1:2];
    assign if_tag   = if_pc[31:BTB_INDEX_BITS+2];
    assign id_tag   = id_pc[31:BTB_INDEX_BITS+2];

    assign id_kind = (id_opcode == op_jal)  ? KIND_JAL  :
                     (id_opcode == op_jalr) ? KIND_JALR : KIND_BR;

    // both read ports are combinational
    assign if_btb_hit     = valid[if_index] && (tags[if_index] == if_tag);
    assign if_btb_kind    = kinds[if_index];
    assign if_pred_target = targets[if_index];
    assign id_btb_hit     = valid[id_index] && (tags[id_index] == id_tag);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid <= '0;
        else if (btb_load)
            valid[id_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (btb_load)
        begin
            tags[id_index]    <= id_tag;
            targets[id_index] <= id_target;
            kinds[id_index]   <= id_kind;
        end
    end

endmodule

//--- hdl/stall_control_unit.sv
`timescale 1ns/1ns

module stall_control_unit
    import rv32i_pkg::*;
(
    input  logic       instr_mem_resp,
    input  logic       data_mem_resp,
    input  logic       if_btb_hit,
    input  br_kind_t   if_btb_kind,
    input  logic       if_br_pr,
    input  logic       id_btb_hit,
    input  logic       id_br_pr,
    input  logic       id_br_en,
    input  logic       jalr_wrong_target,
    input  opcode_t    id_opcode,
    input  funct3_t    id_funct3,
    input  reg_id_t    id_rs1,
    input  reg_id_t    id_rs2,
    input  opcode_t    ex_opcode,
    input  funct3_t    ex_funct3,
    input  reg_id_t    ex_rd,
    input  reg_id_t    ex_rs1,
    input  reg_id_t    ex_rs2,
    input  opcode_t    mem_opcode,
    input  reg_id_t    mem_rd,
    input  logic       mem_read,
    input  logic       mem_write,
    output logic       load_pc,
    output logic       if_id_reg_load,
    output logic       id_ex_reg_load,
    output logic       ex_mem_reg_load,
    output logic       mem_wb_reg_load,
    output logic       if_id_reg_flush,
    output logic       id_ex_reg_flush,
    output logic       ex_mem_reg_flush,
    output logic       mem_wb_reg_flush,
    output pcmux_sel_t pc_mux_sel,
    output logic       btb_load,
    output logic       ghr_load,
    output logic       increment_pht,
    output logic       decrement_pht,
    output logic       global_stall
);

    logic id_cmp;
    logic id_jalr;
    logic ex_arith;
    logic ex_alu;
    logic ex_dep;
    logic mem_dep;
    logic mem_ex_dep;
    logic raw_stall;
    logic alu_stall;
    logic cache_stall;

    // ID instructions that need their operands in the comparator
    assign id_cmp  = (id_opcode == op_br) ||
                     (((id_opcode == op_reg) || (id_opcode == op_imm)) &&
                      ((id_funct3 == f3_slt) || (id_funct3 == f3_sltu)));
    assign id_jalr = (id_opcode == op_jalr);

    // EX instructions whose result comes from the ALU
    assign ex_arith = ((ex_opcode == op_reg) || (ex_opcode == op_imm)) &&
                      (ex_funct3 != f3_slt) && (ex_funct3 != f3_sltu);
    assign ex_alu   = ex_arith || (ex_opcode == op_auipc);

    // jalr reads only rs1
    assign ex_dep  = (ex_rd != '0) &&
                     ((ex_rd == id_rs1) || (id_cmp && (ex_rd == id_rs2)));
    assign mem_dep = (mem_rd != '0) &&
                     ((mem_rd == id_rs1) || (id_cmp && (mem_rd == id_rs2)));

    // store data is forwarded later, only the address base matters here
    assign mem_ex_dep = (mem_rd != '0) &&
                        ((mem_rd == ex_rs1) || (ex_arith && (mem_rd == ex_rs2)));

    assign raw_stall = (id_cmp || id_jalr) &&
                       (((ex_alu || (ex_opcode == op_load)) && ex_dep) ||
                        ((mem_opcode == op_load) && mem_dep));

    assign alu_stall = (ex_arith || (ex_opcode == op_store)) &&
                       (mem_opcode == op_load) && mem_ex_dep;

    assign cache_stall = !instr_mem_resp || (!data_mem_resp && (mem_read || mem_write));

    always_comb
    begin
        load_pc          = 1'b1;
        if_id_reg_load   = 1'b1;
        id_ex_reg_load   = 1'b1;
        ex_mem_reg_load  = 1'b1;
        mem_wb_reg_load  = 1'b1;
        if_id_reg_flush  = 1'b0;
        id_ex_reg_flush  = 1'b0;
        ex_mem_reg_flush = 1'b0;
        mem_wb_reg_flush = 1'b0;
        pc_mux_sel       = PC_PLUS4;
        btb_load         = 1'b0;
        ghr_load         = 1'b0;
        increment_pht    = 1'b0;
        decrement_pht    = 1'b0;
        global_stall     = 1'b0;

        // hold ID, bubble into EX
        if (raw_stall)
        begin
            load_pc         = 1'b0;
            if_id_reg_load  = 1'b0;
            id_ex_reg_flush = 1'b1;
        end

        // hold ID and EX, bubble into MEM
        if (alu_stall)
        begin
            load_pc          = 1'b0;
            if_id_reg_load   = 1'b0;
            id_ex_reg_load   = 1'b0;
            id_ex_reg_flush  = 1'b0;
            ex_mem_reg_flush = 1'b1;
        end

        // IF redirect, jumps always taken, branches only when predicted
        if (if_btb_hit && ((if_btb_kind != KIND_BR) || if_br_pr))
            pc_mux_sel = BTB_OUT;

        // ID correction and training only when the ID instruction moves on
        if (!raw_stall && !alu_stall)
        begin
            case (id_opcode)
                op_br:
                begin
                    if (id_btb_hit && (id_br_pr != id_br_en))
                    begin
                        if_id_reg_flush = 1'b1;
                        pc_mux_sel      = id_br_en ? ADDER_OUT : IF_ID_PC_PLUS4;
                    end
                    else if (!id_btb_hit && id_br_en)
                    begin
                        if_id_reg_flush = 1'b1;
                        btb_load        = 1'b1;
                        pc_mux_sel      = ADDER_OUT;
                    end
                end
                op_jal:
                begin
                    if (!id_btb_hit)
                    begin
                        if_id_reg_flush = 1'b1;
                        btb_load        = 1'b1;
                        pc_mux_sel      = ADDER_OUT;
                    end
                end
                op_jalr:
                begin
                    if (!id_btb_hit || jalr_wrong_target)
                    begin
                        if_id_reg_flush = 1'b1;
                        btb_load        = 1'b1;
                        pc_mux_sel      = ADDER_MOD2;
                    end
                end
                default:
                begin
                end
            endcase

            if (id_opcode == op_br)
            begin
                ghr_load      = if_id_reg_load;
                increment_pht = id_br_en;
                decrement_pht = !id_br_en;
            end
        end

        // a cache miss freezes every stage, pending flushes and updates wait
        if (cache_stall)
        begin
            load_pc          = 1'b0;
            if_id_reg_load   = 1'b0;
            id_ex_reg_load   = 1'b0;
            ex_mem_reg_load  = 1'b0;
            mem_wb_reg_load  = 1'b0;
            if_id_reg_flush  = 1'b0;
            id_ex_reg_flush  = 1'b0;
            ex_mem_reg_flush = 1'b0;
            mem_wb_reg_flush = 1'b0;
            btb_load         = 1'b0;
            ghr_load         = 1'b0;
            increment_pht    = 1'b0;
            decrement_pht    = 1'b0;
            global_stall     = 1'b1;
        end
    end

endmodule

//--- hdl/ctrl_pipe.sv
`timescale 1ns/1ns

module ctrl_pipe
    import rv32i_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  word_t   id_instr,
    input  logic    if_id_reg_load,
    input  logic    id_ex_reg_load,
    input  logic    ex_mem_reg_load,
    input  logic    mem_wb_reg_load,
    input  logic    if_id_reg_flush,
    input  logic    id_ex_reg_flush,
    input  logic    ex_mem_reg_flush,
    input  logic    mem_wb_reg_flush,
    output opcode_t id_opcode,
    output funct3_t id_funct3,
    output reg_id_t id_rs1,
    output reg_id_t id_rs2,
    output opcode_t ex_opcode,
    output funct3_t ex_funct3,
    output reg_id_t ex_rd,
    output reg_id_t ex_rs1,
    output reg_id_t ex_rs2,
    output opcode_t mem_opcode,
    output reg_id_t mem_rd,
    output logic    mem_read,
    output logic    mem_write,
    output opcode_t wb_opcode,
    output reg_id_t wb_rd
);

    logic    id_valid;
    logic    id_writes_rd;
    reg_id_t id_rd;
    logic    id_mem_read;
    logic    id_mem_write;
    logic    ex_mem_read;
    logic    ex_mem_write;

    // tracks whether the IF/ID slot holds a live instruction
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            id_valid <= 1'b0;
        else if (if_id_reg_flush)
            id_valid <= 1'b0;
        else if (if_id_reg_load)
            id_valid <= 1'b1;
    end

    assign id_opcode = id_valid ? id_instr[6:0] : op_bubble;
    assign id_funct3 = id_valid ? id_instr[14:12] : '0;
    assign id_rs1    = id_valid ? id_instr[19:15] : '0;
    assign id_rs2    = id_valid ? id_instr[24:20] : '0;

    // branches and stores carry immediate bits in the rd field
    assign id_writes_rd = (id_opcode == op_lui) || (id_opcode == op_auipc) ||
                          (id_opcode == op_jal) || (id_opcode == op_jalr) ||
                          (id_opcode == op_load) || (id_opcode == op_imm) ||
                          (id_opcode == op_reg);

    assign id_rd        = id_writes_rd ? id_instr[11:7] : '0;
    assign id_mem_read  = (id_opcode == op_load);
    assign id_mem_write = (id_opcode == op_store);

    // ID/EX
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_opcode    <= op_bubble;
            ex_funct3    <= '0;
            ex_rd        <= '0;
            ex_rs1       <= '0;
            ex_rs2       <= '0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else if (id_ex_reg_flush)
        begin
            ex_opcode    <= op_bubble;
            ex_funct3    <= '0;
            ex_rd        <= '0;
            ex_rs1       <= '0;
            ex_rs2       <= '0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else if (id_ex_reg_load)
        begin
            ex_opcode    <= id_opcode;
            ex_funct3    <= id_funct3;
            ex_rd        <= id_rd;
            ex_rs1       <= id_rs1;
            ex_rs2       <= id_rs2;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
        end
    end

    // EX/MEM
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_opcode <= op_bubble;
            mem_rd     <= '0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
        end
        else if (ex_mem_reg_flush)
        begin
            mem_opcode <= op_bubble;
            mem_rd     <= '0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
        end
        else if (ex_mem_reg_load)
        begin
            mem_opcode <= ex_opcode;
            mem_rd     <= ex_rd;
            mem_read   <= ex_mem_read;
            mem_write  <= ex_mem_write;
        end
    end

    // MEM/WB
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_opcode <= op_bubble;
            wb_rd     <= '0;
        end
        else if (mem_wb_reg_flush)
        begin
            wb_opcode <= op_bubble;
            wb_rd     <= '0;
        end
        else if (mem_wb_reg_load)
        begin
            wb_opcode <= mem_opcode;
            wb_rd     <= mem_rd;
        end
    end

endmodule

//--- common/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  pcmux_sel_t;
    typedef logic [1:0]  br_kind_t;
    typedef logic [1:0]  ctr_t;

    // rv32i base opcodes, zero marks a bubble
    localparam opcode_t op_bubble = 7'b0000000;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_br     = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;

    // compare-type arithmetic, resolved by the ID comparator
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;

    // next pc sources
    localparam pcmux_sel_t PC_PLUS4       = 3'd0;
    localparam pcmux_sel_t BTB_OUT        = 3'd1;
    localparam pcmux_sel_t ADDER_OUT      = 3'd2;
    localparam pcmux_sel_t IF_ID_PC_PLUS4 = 3'd3;
    localparam pcmux_sel_t ADDER_MOD2     = 3'd4;

    // control-transfer kind stored per btb entry
    localparam br_kind_t KIND_BR   = 2'd0;
    localparam br_kind_t KIND_JAL  = 2'd1;
    localparam br_kind_t KIND_JALR = 2'd2;

    // btb index is pc[5:2], tag is pc[31:6]
    localparam int BTB_INDEX_BITS = 4;
    localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
    localparam int BTB_TAG_BITS   = 32 - BTB_INDEX_BITS - 2;

    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;

    // gshare history and pattern table
    localparam int GHR_BITS    = 4;
    localparam int PHT_ENTRIES = 1 << GHR_BITS;

    typedef logic [GHR_BITS-1:0] ghr_t;

    // weakly not taken
    localparam ctr_t PHT_INIT = 2'd1;
    localparam ctr_t CTR_MAX  = 2'd3;

endpackage
